// ==== fifo_pkg.sv ====
// ========================================
// fifo_pkg
// depth and counter widths shared by the
// request and response queues.
// ========================================

package fifo_pkg;

  // entries per queue.
  localparam int unsigned FIFO_DEPTH = 4;

  // read and write pointer width.
  localparam int unsigned FIFO_PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // occupancy counter, counts 0 to FIFO_DEPTH.
  localparam int unsigned FIFO_CW = $clog2(FIFO_DEPTH + 1);

endpackage

// ==== tcdm_pkg.sv ====
// ========================================
// tcdm_pkg
// bus widths of the tcdm port and the
// request word as one packed union that
// has a flat view and a field view.
// ========================================

package tcdm_pkg;

  // byte address.
  localparam int unsigned ADDR_W = 32;

  // one data word per request and response.
  localparam int unsigned DATA_W = 32;

  // one enable per data byte.
  localparam int unsigned BE_W = DATA_W / 8;

  // add + data + be + wen, 69 bits.
  localparam int unsigned REQ_W = ADDR_W + DATA_W + BE_W + 1;

  // one request word, decoded two ways.
  // the queue stores the flat view.
  // initiator and memory side use the fields.
  // field order puts add in the top bits.
  typedef union packed {
    logic [REQ_W-1:0] flat;
    struct packed {
      logic [ADDR_W-1:0] add;
      logic [DATA_W-1:0] data;
      logic [BE_W-1:0]   be;
      logic              wen;
    } fields;
  } tcdm_req_u;

endpackage

// ==== stream_fifo.sv ====
// ========================================
// stream_fifo
// registered valid/ready queue of
// FIFO_DEPTH entries, no fall-through.
// empty and full flags, synchronous clear.
// ========================================

`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  input  logic                  pop_ready_i,
  output logic                  empty_o,
  output logic                  full_o
);

  import fifo_pkg::*;

  // storage, written only on an accepted push.
  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];

  logic [FIFO_PW-1:0] wr_ptr_q;
  logic [FIFO_PW-1:0] rd_ptr_q;
  logic [FIFO_CW-1:0] count_q;
  logic               push;
  logic               pop;

  // flags straight from the counter.
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == FIFO_CW'(FIFO_DEPTH));

  assign push_ready_o = ~full_o;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  // accepted transfers.
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap at FIFO_DEPTH-1.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count alone.
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // pointers meet on a non-empty queue only when it is full.
  // push_ready is then low before a push can overwrite the head.
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((wr_ptr_q == rd_ptr_q) && !empty_o) |-> full_o)
    else $error("stream_fifo: push could overwrite the unread head");

  // pointers meet on a non-full queue only when it is empty.
  // pop_valid is then low before a stale entry can leave.
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((wr_ptr_q == rd_ptr_q) && !full_o) |-> empty_o)
    else $error("stream_fifo: pop could return a stale entry");

endmodule

// ==== req_path.sv ====
// ========================================
// req_path
// packs initiator request fields into one
// word, queues it and unpacks the queue
// head toward the memory port.
// ========================================

`timescale 1ns/1ps

module req_path (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0] add_i,
  input  logic [tcdm_pkg::DATA_W-1:0] data_i,
  input  logic [tcdm_pkg::BE_W-1:0]   be_i,
  input  logic                        wen_i,
  output logic                        gnt_o,
  input  logic                        req_pop_i,
  output logic                        req_valid_o,
  output logic                        req_empty_o,
  output logic [tcdm_pkg::ADDR_W-1:0] mem_add_o,
  output logic [tcdm_pkg::DATA_W-1:0] mem_data_o,
  output logic [tcdm_pkg::BE_W-1:0]   mem_be_o,
  output logic                        mem_wen_o
);

  import tcdm_pkg::*;

  tcdm_req_u push_word;
  tcdm_req_u pop_word;

  // initiator side writes the fields.
  always_comb begin
    push_word.fields.add  = add_i;
    push_word.fields.data = data_i;
    push_word.fields.be   = be_i;
    push_word.fields.wen  = wen_i;
  end

  // req/gnt map onto push valid/ready.
  // gnt is high whenever the queue has room.
  stream_fifo #(
    .DATA_WIDTH ( REQ_W )
  ) req_fifo_inst (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( req_i          ),
    .push_data_i  ( push_word.flat ),
    .push_ready_o ( gnt_o          ),
    .pop_valid_o  ( req_valid_o    ),
    .pop_data_o   ( pop_word.flat  ),
    .pop_ready_i  ( req_pop_i      ),
    .empty_o      ( req_empty_o    ),
    .full_o       (                )
  );

  // memory side reads the head back as fields.
  assign mem_add_o  = pop_word.fields.add;
  assign mem_data_o = pop_word.fields.data;
  assign mem_be_o   = pop_word.fields.be;
  assign mem_wen_o  = pop_word.fields.wen;

  // head held until the memory grant pops it.
  a_add_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_o && !req_pop_i && !clear_i) |=> $stable(mem_add_o))
    else $error("req_path: mem_add_o changed before grant");

endmodule

// ==== resp_path.sv ====
// ========================================
// resp_path
// catches each memory response pulse,
// holds it while the response queue is
// full and queues it toward the initiator.
// ========================================

`timescale 1ns/1ps

module resp_path (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        mem_r_valid_i,
  input  logic [tcdm_pkg::DATA_W-1:0] mem_r_data_i,
  input  logic                        rsp_ready_i,
  output logic                        r_valid_o,
  output logic [tcdm_pkg::DATA_W-1:0] r_data_o,
  output logic                        resp_not_full_o,
  output logic                        resp_empty_o
);

  import tcdm_pkg::*;

  // one-entry capture register.
  logic              cap_valid_q;
  logic [DATA_W-1:0] cap_data_q;

  logic              push_valid;
  logic [DATA_W-1:0] push_data;
  logic              push_ready;

  // live pulse first, held entry otherwise.
  assign push_valid = mem_r_valid_i | cap_valid_q;
  assign push_data  = mem_r_valid_i ? mem_r_data_i : cap_data_q;

  // set on a pulse the queue refuses.
  // cleared once the queue takes the held entry.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_valid_q <= 1'b0;
    end else if (clear_i) begin
      cap_valid_q <= 1'b0;
    end else if (mem_r_valid_i) begin
      cap_valid_q <= ~push_ready;
    end else if (push_ready) begin
      cap_valid_q <= 1'b0;
    end
  end

  // data only, qualified by cap_valid_q.
  always_ff @(posedge clk_i) begin
    if (mem_r_valid_i && !push_ready) begin
      cap_data_q <= mem_r_data_i;
    end
  end

  // response queue, drained by the initiator's ready level.
  stream_fifo #(
    .DATA_WIDTH ( DATA_W )
  ) resp_fifo_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .push_valid_i ( push_valid   ),
    .push_data_i  ( push_data    ),
    .push_ready_o ( push_ready   ),
    .pop_valid_o  ( r_valid_o    ),
    .pop_data_o   ( r_data_o     ),
    .pop_ready_i  ( rsp_ready_i  ),
    .empty_o      ( resp_empty_o ),
    .full_o       (              )
  );

  assign resp_not_full_o = push_ready;

  // request gating upstream keeps a second response from landing.
  a_no_cap_overrun : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cap_valid_q && !push_ready) |-> !mem_r_valid_i)
    else $error("resp_path: response lost, capture register busy");

endmodule

// ==== decouple_ctrl.sv ====
// ========================================
// decouple_ctrl
// issues memory requests only while the
// response queue has room, pops the
// request queue on grant, merges flags.
// ========================================

`timescale 1ns/1ps

module decouple_ctrl (
  input  logic req_valid_i,
  input  logic req_empty_i,
  input  logic resp_not_full_i,
  input  logic resp_empty_i,
  input  logic mem_gnt_i,
  output logic mem_req_o,
  output logic req_pop_o,
  output logic empty_o
);

  // pending request and room for its response.
  // the capture register covers the one in flight
  // when the queue turns full.
  assign mem_req_o = req_valid_i & resp_not_full_i;

  // grant only comes with mem_req_o, so the head is valid.
  assign req_pop_o = mem_gnt_i;

  // idle when both queues hold nothing.
  assign empty_o = req_empty_i & resp_empty_i;

  // memory must not grant a request that is not issued.
  always_comb begin
    a_gnt_with_req : assert final (!mem_gnt_i || mem_req_o)
      else $error("decouple_ctrl: mem_gnt_i without mem_req_o");
  end

endmodule

// ==== tcdm_fifo_top.sv ====
// ========================================
// tcdm_fifo_top
// decoupling buffer between a streamer
// and a tcdm port: request queue, response
// capture and queue, and request gating.
// ========================================

`timescale 1ns/1ps

module tcdm_fifo_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  // initiator side.
  input  logic                        req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0] add_i,
  input  logic [tcdm_pkg::DATA_W-1:0] data_i,
  input  logic [tcdm_pkg::BE_W-1:0]   be_i,
  input  logic                        wen_i,
  input  logic                        rsp_ready_i,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [tcdm_pkg::DATA_W-1:0] r_data_o,
  // memory side.
  output logic                        mem_req_o,
  output logic [tcdm_pkg::ADDR_W-1:0] mem_add_o,
  output logic [tcdm_pkg::DATA_W-1:0] mem_data_o,
  output logic [tcdm_pkg::BE_W-1:0]   mem_be_o,
  output logic                        mem_wen_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_r_valid_i,
  input  logic [tcdm_pkg::DATA_W-1:0] mem_r_data_i,
  output logic                        empty_o
);

  // status and pop between the paths and control.
  logic req_valid;
  logic req_empty;
  logic req_pop;
  logic resp_not_full;
  logic resp_empty;

  decouple_ctrl decouple_ctrl_inst (
    .req_valid_i     ( req_valid     ),
    .req_empty_i     ( req_empty     ),
    .resp_not_full_i ( resp_not_full ),
    .resp_empty_i    ( resp_empty    ),
    .mem_gnt_i       ( mem_gnt_i     ),
    .mem_req_o       ( mem_req_o     ),
    .req_pop_o       ( req_pop       ),
    .empty_o         ( empty_o       )
  );

  req_path req_path_inst (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .clear_i     ( clear_i    ),
    .req_i       ( req_i      ),
    .add_i       ( add_i      ),
    .data_i      ( data_i     ),
    .be_i        ( be_i       ),
    .wen_i       ( wen_i      ),
    .gnt_o       ( gnt_o      ),
    .req_pop_i   ( req_pop    ),
    .req_valid_o ( req_valid  ),
    .req_empty_o ( req_empty  ),
    .mem_add_o   ( mem_add_o  ),
    .mem_data_o  ( mem_data_o ),
    .mem_be_o    ( mem_be_o   ),
    .mem_wen_o   ( mem_wen_o  )
  );

  resp_path resp_path_inst (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .mem_r_valid_i   ( mem_r_valid_i ),
    .mem_r_data_i    ( mem_r_data_i  ),
    .rsp_ready_i     ( rsp_ready_i   ),
    .r_valid_o       ( r_valid_o     ),
    .r_data_o        ( r_data_o      ),
    .resp_not_full_o ( resp_not_full ),
    .resp_empty_o    ( resp_empty    )
  );

endmodule

// ==== tb_tcdm_fifo.sv ====
// ========================================
// tb_tcdm_fifo
// random traffic through the decoupling
// buffer with a memory model and response
// scoreboard, checked by assertions.
// ========================================

`timescale 1ns/1ps

module tb_tcdm_fifo;

  import tcdm_pkg::*;
  import fifo_pkg::*;

  localparam int MEM_WORDS = 64;
  localparam int SEED      = 98;
  localparam int TIMEOUT   = 2000;

  logic              clk_i         = 1'b0;
  logic              rst_ni        = 1'b0;
  logic              clear_i       = 1'b0;
  logic              req_i         = 1'b0;
  logic [ADDR_W-1:0] add_i         = '0;
  logic [DATA_W-1:0] data_i        = '0;
  logic [BE_W-1:0]   be_i          = '0;
  logic              wen_i         = 1'b0;
  logic              rsp_ready_i   = 1'b0;
  logic              mem_r_valid_i = 1'b0;
  logic [DATA_W-1:0] mem_r_data_i  = '0;
  logic              mem_gnt_i;
  logic              gnt_o;
  logic              r_valid_o;
  logic [DATA_W-1:0] r_data_o;
  logic              mem_req_o;
  logic [ADDR_W-1:0] mem_add_o;
  logic [DATA_W-1:0] mem_data_o;
  logic [BE_W-1:0]   mem_be_o;
  logic              mem_wen_o;
  logic              empty_o;

  // memory model, reference copy and expected responses.
  logic [DATA_W-1:0] mem_arr [MEM_WORDS];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  logic [DATA_W-1:0] exp_q [$];
  logic [DATA_W-1:0] exp_head;
  int                exp_cnt;
  int                req_cnt;
  int                in_fifo;
  int                req_total;
  int                rsp_total;
  int                errors;
  bit                timed_out;
  logic              gnt_roll     = 1'b0;
  logic              gnt_hold_low = 1'b0;
  logic              ready_low    = 1'b0;

  tcdm_fifo_top tcdm_fifo_top_inst (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // start-up contents, different in every word.
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return 32'h5a3c_0f00 ^ (idx * 32'h0101_0101) ^ (idx << 20);
  endfunction

  // only the enabled bytes take the new data.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // memory grants at random, never without a request.
  assign mem_gnt_i = mem_req_o & gnt_roll;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) mem_arr[i] = fill_word(i);
      gnt_roll      <= 1'b0;
      mem_r_valid_i <= 1'b0;
    end else begin
      // one response per grant, a cycle later.
      mem_r_valid_i <= mem_req_o & mem_gnt_i;
      if (mem_req_o && mem_gnt_i) begin
        if (mem_wen_o) begin
          mem_arr[mem_add_o[7:2]] = merge_bytes(mem_arr[mem_add_o[7:2]], mem_data_o, mem_be_o);
          mem_r_data_i <= '0;
        end else begin
          mem_r_data_i <= mem_arr[mem_add_o[7:2]];
        end
      end
      gnt_roll <= !gnt_hold_low && ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    rsp_ready_i <= !ready_low && ($urandom_range(0, 3) != 0);
  end

  // scoreboard, reference memory updated in acceptance order.
  always @(posedge clk_i) begin
    if (!rst_ni || clear_i) begin
      if (!rst_ni) begin
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = fill_word(i);
      end
      exp_q.delete();
      in_fifo = 0;
    end else begin
      if (r_valid_o && rsp_ready_i) begin
        if (exp_q.size() > 0) void'(exp_q.pop_front());
        rsp_total++;
      end
      if (req_i && gnt_o) begin
        if (wen_i) begin
          ref_mem[add_i[7:2]] = merge_bytes(ref_mem[add_i[7:2]], data_i, be_i);
          exp_q.push_back('0);
        end else begin
          exp_q.push_back(ref_mem[add_i[7:2]]);
        end
        req_total++;
        in_fifo = in_fifo + 1;
      end
      if (mem_req_o && mem_gnt_i) in_fifo = in_fifo - 1;
    end
    exp_cnt  <= exp_q.size();
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    req_cnt  <= in_fifo;
  end

  a_rsp_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && rsp_ready_i) |-> (exp_cnt > 0 && r_data_o == exp_head))
    else begin
      errors++;
      $display("FAIL t=%0t r_data_o expected %h got %h (outstanding %0d)", $time,
               $sampled(exp_head), $sampled(r_data_o), $sampled(exp_cnt));
    end

  // request queue holds FIFO_DEPTH entries not yet taken by memory.
  a_gnt_level : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o == (req_cnt < int'(FIFO_DEPTH)))
    else begin
      errors++;
      $display("FAIL t=%0t gnt_o expected %b got %b", $time,
               $sampled(req_cnt) < int'(FIFO_DEPTH), $sampled(gnt_o));
    end

  a_mem_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_gnt_i && !clear_i)
      |=> $stable({mem_add_o, mem_data_o, mem_be_o, mem_wen_o}))
    else begin
      errors++;
      $display("t=%0t memory-side fields changed while the request waited", $time);
    end

  a_rsp_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && !rsp_ready_i && !clear_i) |=> (r_valid_o && $stable(r_data_o)))
    else begin
      errors++;
      $display("t=%0t response dropped or changed while the initiator stalled", $time);
    end

  a_idle_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exp_cnt == 0) |-> empty_o)
    else begin
      errors++;
      $display("FAIL t=%0t empty_o expected 1 got %b", $time, $sampled(empty_o));
    end

  a_busy_not_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_cnt > 0) |-> !empty_o)
    else begin
      errors++;
      $display("FAIL t=%0t empty_o expected 0 got %b", $time, $sampled(empty_o));
    end

  task automatic check_idle_flags(input string when);
    @(negedge clk_i);
    assert (empty_o && gnt_o && !mem_req_o && !r_valid_o)
      else begin
        errors++;
        $display("FAIL t=%0t empty_o/gnt_o/mem_req_o/r_valid_o (%s) expected 1100 got %b%b%b%b",
                 $time, when, empty_o, gnt_o, mem_req_o, r_valid_o);
      end
  endtask

  task automatic drive_request();
    logic write;
    write = ($urandom_range(0, 1) == 1);
    req_i  <= 1'b1;
    wen_i  <= write;
    // small address range so reads often hit earlier writes.
    add_i  <= {24'h0, 6'($urandom_range(0, 15)), 2'b00};
    data_i <= $urandom();
    be_i   <= write ? 4'($urandom_range(0, 15)) : 4'hf;
  endtask

  task automatic issue_requests(input int n);
    int sent;
    int stall;
    sent  = 0;
    stall = 0;
    @(posedge clk_i);
    drive_request();
    while (sent < n && !timed_out) begin
      // gnt_o at the negedge decides the coming edge.
      @(negedge clk_i);
      if (gnt_o) begin
        sent++;
        stall = 0;
      end else begin
        stall++;
        if (stall > TIMEOUT) begin
          $display("timeout: request not granted within %0d cycles", TIMEOUT);
          timed_out = 1'b1;
        end
      end
      @(posedge clk_i);
      if (sent == n || timed_out) req_i <= 1'b0;
      else if (stall == 0) drive_request();
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!timed_out && !(exp_cnt == 0 && empty_o)) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: outstanding responses not drained within %0d cycles", TIMEOUT);
        timed_out = 1'b1;
      end else begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic run_phases();
    issue_requests(200);
    wait_idle();
    if (timed_out) return;
    // memory grant held off, request queue backs up.
    gnt_hold_low <= 1'b1;
    fork
      issue_requests(int'(FIFO_DEPTH) + 2);
      begin
        repeat (24) @(posedge clk_i);
        gnt_hold_low <= 1'b0;
      end
    join
    wait_idle();
    if (timed_out) return;
    // initiator stalls, responses pile up.
    ready_low <= 1'b1;
    fork
      issue_requests(12);
      begin
        repeat (40) @(posedge clk_i);
        ready_low <= 1'b0;
      end
    join
    wait_idle();
    if (timed_out) return;
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    check_idle_flags("clear");
    issue_requests(40);
    wait_idle();
    if (!timed_out) check_idle_flags("drain");
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_idle_flags("reset");
    run_phases();
    assert (rsp_total == req_total)
      else begin
        errors++;
        $display("FAIL t=%0t response count expected %0d got %0d", $time, req_total, rsp_total);
      end
    $display("errors=%0d timeouts=%0d requests=%0d responses=%0d",
             errors, timed_out, req_total, rsp_total);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
fifo_pkg.sv
tcdm_pkg.sv
stream_fifo.sv
req_path.sv
resp_path.sv
decouple_ctrl.sv
tcdm_fifo_top.sv
tb_tcdm_fifo.sv

// ==== Makefile ====
# Verilator build and run of the tcdm decoupling buffer testbench.
SIM = obj_dir/Vtb_tcdm_fifo

all: run

# rebuilt only when a source or the file list changes.
$(SIM): sim.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_tcdm_fifo -f sim.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
